// ==== verilog/pad_defines.svh ====
`ifndef PAD_DEFINES_SVH
`define PAD_DEFINES_SVH

// nes poll timing, counted in clk cycles

// latch pulse length and full bit slot, roughly 12 us
`define NES_LATCH_CYCLES 300

// nes_clk high time in a slot, also the wait before A
`define NES_HALF_BIT_CYCLES 150

// slot counter width, must hold NES_LATCH_CYCLES
`define NES_COUNT_W 11

// frame sizes

// A B select start up down left right
`define NES_BITS 8

// b y select start up down left right a x l r
`define SNES_BITS 12

// frame filter

// more pressed bits than this reads as a corrupt frame
`define PAD_MAX_PRESSED 2

`endif

// ==== verilog/pad_pkg.sv ====
`include "pad_defines.svh"

package pad_pkg;

    // named view of one pmod frame
    // msb arrives first on the wire
    typedef struct packed {
        logic b;
        logic y;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic x;
        logic l;
        logic r;
    } snes_btn_t;

    // one 12-bit frame, read as a word or as buttons
    typedef union packed {
        logic [`SNES_BITS-1:0] raw;  // all-ones test, popcount
        snes_btn_t             btn;  // per-button access
    } snes_frame_u;

    // nes poll sequence
    // bit index lives beside the state, not in it
    typedef enum logic [1:0] {
        st_latch,     // latch high, pad loads its buttons
        st_wait_a,    // A already on data, sample then wait
        st_bit_slot   // clock pulse per remaining button
    } nes_state_e;

endpackage

// ==== verilog/nes_poller.sv ====
`include "pad_defines.svh"

// polls an nes pad
// latch pulse, A read straight after, then one clock pulse per button
module nes_poller
    import pad_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 nes_data,    // serial from pad, low = pressed
    output logic                 nes_latch,
    output logic                 nes_clk,
    output logic [`NES_BITS-1:0] nes_buttons  // A at msb, 1 = pressed
);

    localparam int idx_w = $clog2(`NES_BITS);

    typedef logic [`NES_COUNT_W-1:0] count_t;

    // last count of a latch pulse or bit slot
    localparam count_t slot_last = count_t'(`NES_LATCH_CYCLES);
    // last nes_clk high count, also the sample point
    localparam count_t half_last = count_t'(`NES_HALF_BIT_CYCLES);
    // index of the right button, last in the frame
    localparam logic [idx_w-1:0] idx_last = idx_w'(`NES_BITS - 1);

    nes_state_e       state;
    count_t           count;   // shared by all states
    logic [idx_w-1:0] idx;     // 0 = A ... idx_last = right

    logic slot_done;
    logic half_done;

    assign slot_done = (count == slot_last);
    assign half_done = (count == half_last);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_latch;
            count       <= '0;
            idx         <= '0;
            nes_latch   <= 1'b0;   // rises one cycle after reset
            nes_clk     <= 1'b0;
            nes_buttons <= '0;     // all released
        end else begin
            count <= count + count_t'(1);  // default advance

            case (state)
                st_latch: begin
                    nes_latch <= 1'b1;
                    if (slot_done) begin
                        nes_latch <= 1'b0;
                        count     <= '0;
                        idx       <= '0;
                        state     <= st_wait_a;
                    end
                end

                st_wait_a: begin
                    // pad drives A as soon as latch drops
                    if (count == '0) begin
                        nes_buttons[idx_last - idx] <= ~nes_data;
                    end
                    if (half_done) begin
                        nes_clk <= 1'b1;       // first slot opens high
                        count   <= '0;
                        idx     <= idx_w'(1);  // B next
                        state   <= st_bit_slot;
                    end
                end

                st_bit_slot: begin
                    // pad shifted on our rising edge
                    // data settled by the end of the high phase
                    if (half_done) begin
                        nes_clk                     <= 1'b0;
                        nes_buttons[idx_last - idx] <= ~nes_data;
                    end

                    if (slot_done) begin
                        count <= '0;
                        if (idx == idx_last) begin
                            // right done, next frame
                            nes_latch <= 1'b1;
                            state     <= st_latch;
                        end else begin
                            nes_clk <= 1'b1;
                            idx     <= idx + idx_w'(1);
                        end
                    end
                end

                default: begin
                    count <= '0;
                    state <= st_latch;
                end
            endcase
        end
    end

endmodule

// ==== verilog/pmod_frame_capture.sv ====
`include "pad_defines.svh"

// pmod bridge receiver
// bridge clocks its own frames, we oversample them with clk
module pmod_frame_capture
    import pad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pmod_data,
    input  logic        pmod_clk,
    input  logic        pmod_latch,
    output snes_frame_u frame       // last committed frame
);

    // pin vectors packed as {data, clk, latch}
    logic [2:0] pin_meta;   // first sync stage
    logic [2:0] pin_sync;   // second sync stage, safe to use

    logic clk_prev;
    logic latch_prev;
    logic clk_rise;
    logic latch_rise;

    logic [`SNES_BITS-1:0] shift_q;

    assign clk_rise   = pin_sync[1] & ~clk_prev;
    assign latch_rise = pin_sync[0] & ~latch_prev;

    // two-flop synchronizer on all three pins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_meta <= '0;
            pin_sync <= '0;
        end else begin
            pin_meta <= {pmod_data, pmod_clk, pmod_latch};
            pin_sync <= pin_meta;
        end
    end

    // edge detect, shift on clock, commit on latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
            shift_q    <= '1;   // all ones = no pad
            frame.raw  <= '1;
        end else begin
            clk_prev   <= pin_sync[1];
            latch_prev <= pin_sync[0];

            if (clk_rise) begin
                shift_q <= {shift_q[`SNES_BITS-2:0], pin_sync[2]};  // msb first
            end

            if (latch_rise) begin
                frame.raw <= shift_q;  // 3 cycles after the pin rise
            end
        end
    end

endmodule

// ==== verilog/snes_frame_decoder.sv ====
`include "pad_defines.svh"

// snes frame to buttons
// bridge sends all ones with no pad attached
// now and then it sends garbage with many bits set, dropped here
module snes_frame_decoder
    import pad_pkg::*;
(
    input  snes_frame_u           frame,
    output logic [`SNES_BITS-1:0] snes_buttons,  // frame field order
    output logic                  snes_present
);

    localparam int cnt_w = $clog2(`SNES_BITS + 1);

    // threshold in counter width
    localparam logic [cnt_w-1:0] max_pressed = cnt_w'(`PAD_MAX_PRESSED);

    logic [cnt_w-1:0] pressed;     // set bits in the raw word
    logic             too_many;

    // popcount over the raw view
    always_comb begin
        pressed = '0;
        for (int i = 0; i < `SNES_BITS; i++) begin
            pressed = pressed + cnt_w'(frame.raw[i]);
        end
    end

    assign snes_present = (frame.raw != '1);
    assign too_many     = (pressed > max_pressed);

    // absent or implausible frame reads as nothing pressed
    always_comb begin
        if (!snes_present || too_many) begin
            snes_buttons = '0;
        end else begin
            snes_buttons = frame.raw;
        end
    end

endmodule

// ==== verilog/pad_select_top.sv ====
`include "pad_defines.svh"

// game pad front end
// nes pad polled here, snes pad through the pmod bridge
// snes wins while one is plugged in
module pad_select_top
    import pad_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // nes pad
    input  logic                  nes_data,
    output logic                  nes_latch,
    output logic                  nes_clk,

    // pmod bridge
    input  logic                  pmod_data,
    input  logic                  pmod_clk,
    input  logic                  pmod_latch,

    output logic [`SNES_BITS-1:0] buttons,      // b y sel start u d l r a x l r
    output logic                  snes_active   // 1 = snes source
);

    logic [`NES_BITS-1:0]  nes_buttons;   // A B sel start u d l r
    snes_frame_u           snes_frame;
    logic [`SNES_BITS-1:0] snes_buttons;
    logic                  snes_present;
    snes_frame_u           nes_map;       // nes buttons in snes layout

    nes_poller u_nes (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_buttons (nes_buttons)
    );

    pmod_frame_capture u_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmod_data  (pmod_data),
        .pmod_clk   (pmod_clk),
        .pmod_latch (pmod_latch),
        .frame      (snes_frame)
    );

    snes_frame_decoder u_decode (
        .frame        (snes_frame),
        .snes_buttons (snes_buttons),
        .snes_present (snes_present)
    );

    // place nes buttons by name
    // y x l r have no nes counterpart and stay 0
    always_comb begin
        nes_map            = '0;
        nes_map.btn.a      = nes_buttons[7];
        nes_map.btn.b      = nes_buttons[6];
        nes_map.btn.select = nes_buttons[5];
        nes_map.btn.start  = nes_buttons[4];
        nes_map.btn.up     = nes_buttons[3];
        nes_map.btn.down   = nes_buttons[2];
        nes_map.btn.left   = nes_buttons[1];
        nes_map.btn.right  = nes_buttons[0];
    end

    // source select, levels only
    assign buttons     = snes_present ? snes_buttons : nes_map.raw;
    assign snes_active = snes_present;  // low after reset, frame resets to all ones

endmodule

// ==== testbench/tb_pad_select.sv ====
`include "pad_defines.svh"

module tb_pad_select;

    // one full nes poll, latch + wait_a + seven slots
    localparam int frame_cycles = (`NES_LATCH_CYCLES + 1) * 8 + `NES_HALF_BIT_CYCLES + 1;
    localparam int rise_timeout = 2 * frame_cycles;        // per latch rise
    localparam int watchdog_cycles = 12 * frame_cycles + 10000;

    logic        clk;
    logic        rst_n;
    logic        nes_data;
    logic        nes_latch;
    logic        nes_clk;
    logic        pmod_data;
    logic        pmod_clk;
    logic        pmod_latch;
    logic [11:0] buttons;
    logic        snes_active;

    // nes pad model state
    logic [7:0] nes_pattern;                // A at msb, 1 = pressed
    logic [7:0] nes_shift = 8'h00;
    logic       nes_clk_q = 1'b0;

    int errors;
    int checks;

    pad_select_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .pmod_data   (pmod_data),
        .pmod_clk    (pmod_clk),
        .pmod_latch  (pmod_latch),
        .buttons     (buttons),
        .snes_active (snes_active)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // pad loads while latch is high, shifts on nes_clk rise
    always @(posedge clk) begin
        #1;     // poller outputs settled
        if (nes_latch) begin
            nes_shift = nes_pattern;
        end else if (nes_clk && !nes_clk_q) begin
            nes_shift = {nes_shift[6:0], 1'b0};   // released after the last bit
        end
        nes_clk_q = nes_clk;
    end

    assign nes_data = ~nes_shift[7];  // active low on the wire

    // nes bits in snes order: b y sel start u d l r a x l r
    function automatic logic [11:0] nes_expected(input logic [7:0] p);
        return {p[6], 1'b0, p[5], p[4], p[3], p[2], p[1], p[0], p[7], 3'b000};
    endfunction

    task automatic check_value(input string name, input logic [11:0] got,
                               input logic [11:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s finished, %0d errors", name, errors - err_before);
    endtask

    // next rising edge, then a small skew
    task automatic edge_skew();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_latch_rises(input int n);
        int   seen;
        int   cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = nes_latch;
        while (seen < n && cycles < n * rise_timeout) begin
            @(negedge clk);
            if (nes_latch && !prev) seen++;
            prev = nes_latch;
            cycles++;
        end
        assert (seen >= n) else begin
            $display("nes_latch did not rise %0d times in time", n);
            errors++;
        end
        @(negedge clk);     // outputs settled here
    endtask

    // msb first, each level held 4 cycles, latch pulse at the end
    task automatic send_pmod_frame(input logic [11:0] f);
        for (int i = 11; i >= 0; i--) begin
            edge_skew();
            pmod_data = f[i];
            pmod_clk  = 1'b0;
            repeat (3) @(posedge clk);
            edge_skew();
            pmod_clk = 1'b1;
            repeat (3) @(posedge clk);
        end
        edge_skew();
        pmod_clk   = 1'b0;
        pmod_latch = 1'b1;
        repeat (3) @(posedge clk);
        edge_skew();
        pmod_latch = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic reset_test();
        int   err_before;
        int   cycles;
        logic clk_was_high;
        err_before   = errors;
        clk_was_high = 1'b0;
        cycles       = 0;
        @(negedge clk);
        check_value("snes_active", 12'(snes_active), 12'h000);
        check_value("buttons", buttons, 12'h000);
        while (!nes_latch && cycles < rise_timeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (nes_latch) else begin
            $display("nes_latch never went high after reset");
            errors++;
        end
        while (nes_latch) begin
            if (nes_clk) clk_was_high = 1'b1;
            @(negedge clk);
        end
        check_value("nes_clk", 12'(clk_was_high), 12'h000);
        report("reset", err_before);
    endtask

    task automatic nes_path_test(input logic [7:0] p);
        int err_before;
        err_before = errors;
        edge_skew();
        nes_pattern = p;
        wait_latch_rises(2);    // one whole frame with the new pattern
        check_value("buttons", buttons, nes_expected(p));
        check_value("buttons y/x/l/r", 12'({buttons[10], buttons[2:0]}), 12'h000);
        check_value("snes_active", 12'(snes_active), 12'h000);
        report($sformatf("nes_path %h", p), err_before);
    endtask

    task automatic snes_select_test(input bit two_bits);
        int          err_before;
        int          i;
        int          j;
        logic [11:0] f;
        err_before = errors;
        i = $urandom % 12;
        j = two_bits ? ($urandom % 12) : i;
        f = (12'h001 << i) | (12'h001 << j);
        edge_skew();
        nes_pattern = 8'($urandom) | 8'hc3;   // at least four nes buttons held
        send_pmod_frame(f);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("snes_active", 12'(snes_active), 12'h001);
        check_value("buttons", buttons, f);
        wait_latch_rises(2);    // nes polled a whole frame, still ignored
        check_value("buttons", buttons, f);
        report($sformatf("snes_select %h", f), err_before);
    endtask

    task automatic filter_test();
        int          err_before;
        logic [11:0] f;
        err_before = errors;
        do begin
            f = 12'($urandom);
        end while ($countones(f) < 3 || f == 12'hfff);
        send_pmod_frame(f);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("snes_active", 12'(snes_active), 12'h001);
        check_value("buttons", buttons, 12'h000);
        report($sformatf("filter %h", f), err_before);
    endtask

    task automatic fallback_test();
        int err_before;
        err_before = errors;
        send_pmod_frame(12'hfff);   // bridge with no pad
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_value("snes_active", 12'(snes_active), 12'h000);
        wait_latch_rises(2);
        check_value("buttons", buttons, nes_expected(nes_pattern));
        report("fallback", err_before);
    endtask

    initial begin
        void'($urandom(34585));
        errors      = 0;
        checks      = 0;
        rst_n       = 1'b0;
        pmod_data   = 1'b0;
        pmod_clk    = 1'b0;
        pmod_latch  = 1'b0;
        nes_pattern = 8'h00;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        reset_test();
        nes_path_test(8'($urandom));
        nes_path_test(8'hff);           // all pressed
        nes_path_test(8'($urandom));
        snes_select_test(1'b0);
        snes_select_test(1'b1);
        filter_test();
        fallback_test();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // hard stop well past the longest test sequence
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/pad_pkg.sv
verilog/nes_poller.sv
verilog/pmod_frame_capture.sv
verilog/snes_frame_decoder.sv
verilog/pad_select_top.sv
testbench/tb_pad_select.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pad front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_pad_select -f compile.f

out=$(./obj_dir/Vtb_pad_select)
echo "$out"

# exits nonzero under set -e when the pass line is missing
echo "$out" | grep -qx "Simulation completed successfully"
echo "run.sh: pass line found"
